// File: logic/chol_pkg.sv
package chol_pkg;

    // Signed Q16.16 matrix element
    typedef logic signed [31:0] fixed_t;

    localparam int FRAC_BITS = 16;
    localparam int WIDE_W    = 64;     // Accumulator and product width

    typedef logic [3:0] idx_t;         // Row or column, N up to 15

    // ==========================================================================
    // Datapath operations

    typedef enum logic [1:0] {
        OP_LOAD = 2'd0,                // acc = x
        OP_MSUB = 2'd1,                // acc -= (x * y) >>> FRAC_BITS
        OP_SQRT = 2'd2,                // L_jj = sqrt(acc)
        OP_DIV  = 2'd3                 // L_ij = acc / x
    } op_kind_t;

    // Row and col name the destination for OP_SQRT and OP_DIV
    typedef struct packed {
        op_kind_t kind;
        idx_t     row;
        idx_t     col;
    } chol_op_t;

    // Write-back of one factor element into the store
    typedef struct packed {
        idx_t   row;
        idx_t   col;
        fixed_t value;
    } chol_wr_t;

endpackage

// File: logic/matrix_store.sv
`timescale 1ns/1ps

module matrix_store #(
    parameter int N = 5
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load,
    input  chol_pkg::fixed_t [N*(N+1)/2-1:0] a_in,
    input  chol_pkg::idx_t                   rd_a_row,
    input  chol_pkg::idx_t                   rd_a_col,
    input  chol_pkg::idx_t                   rd_b_row,
    input  chol_pkg::idx_t                   rd_b_col,
    input  chol_pkg::chol_wr_t               wr,
    input  logic                             wr_valid,
    output chol_pkg::fixed_t                 x,
    output chol_pkg::fixed_t                 y,
    output chol_pkg::fixed_t [N*(N+1)/2-1:0] l_out
);
    import chol_pkg::*;

    localparam int NUM_EL = N * (N + 1) / 2;

    fixed_t [NUM_EL-1:0] mem;          // Lower triangle, row by row

    // Slot of element (r, c), c <= r, in the packed triangle
    function automatic int slot(idx_t r, idx_t c);
        return int'(r) * (int'(r) + 1) / 2 + int'(c);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            mem <= '0;
        end else if (load) begin
            mem <= a_in;                                  // Whole A at once
        end else if (wr_valid) begin
            mem[slot(wr.row, wr.col)] <= wr.value;        // L_ij replaces A_ij
        end
    end

    // Operand ports for the datapath
    assign x = mem[slot(rd_a_row, rd_a_col)];
    assign y = mem[slot(rd_b_row, rd_b_col)];

    assign l_out = mem;

endmodule

// File: logic/col_sequencer.sv
`timescale 1ns/1ps

module col_sequencer #(
    parameter int N = 5
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               op_ready,
    output chol_pkg::chol_op_t op,
    output logic               op_valid,
    output chol_pkg::idx_t     rd_a_row,
    output chol_pkg::idx_t     rd_a_col,
    output chol_pkg::idx_t     rd_b_row,
    output chol_pkg::idx_t     rd_b_col,
    output logic               done
);
    import chol_pkg::*;

    localparam idx_t LAST = idx_t'(N - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,                        // acc = A_ij
        S_MSUB,                        // acc -= L_ik * L_jk
        S_FIN,                         // Root or divide into L_ij
        S_DRAIN                        // Wait for the last write-back
    } state_t;

    state_t state;
    idx_t   j;                         // Column
    idx_t   i;                         // Row, i >= j
    idx_t   k;                         // Inner term, k < j
    logic   fire;

    assign op_valid = state inside {S_LOAD, S_MSUB, S_FIN};
    assign fire     = op_valid && op_ready;

    // ==========================================================================
    // Operation and its operand addresses

    always_comb begin
        op.row   = i;
        op.col   = j;
        rd_a_row = i;
        rd_a_col = j;
        rd_b_row = j;
        rd_b_col = k;
        case (state)
            S_MSUB: begin
                op.kind  = OP_MSUB;
                rd_a_col = k;                             // x = L_ik, y = L_jk
            end
            S_FIN: begin
                op.kind  = (i == j) ? OP_SQRT : OP_DIV;
                rd_a_row = j;                             // Divisor L_jj
            end
            default: begin
                op.kind = OP_LOAD;
            end
        endcase
    end

    // ==========================================================================
    // Column walk

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            done  <= 1'b0;
            j     <= '0;
            i     <= '0;
            k     <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        j     <= '0;
                        i     <= '0;
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    if (fire) begin
                        k     <= '0;
                        state <= (j == '0) ? S_FIN : S_MSUB;  // Column 0 has no terms
                    end
                end
                S_MSUB: begin
                    if (fire) begin
                        if (k == j - 1'b1) begin
                            state <= S_FIN;
                        end else begin
                            k <= k + 1'b1;
                        end
                    end
                end
                S_FIN: begin
                    if (fire) begin
                        if (i != LAST) begin
                            i     <= i + 1'b1;
                            state <= S_LOAD;
                        end else if (j != LAST) begin
                            j     <= j + 1'b1;
                            i     <= j + 1'b1;            // Next column starts on diagonal
                            state <= S_LOAD;
                        end else begin
                            state <= S_DRAIN;
                        end
                    end
                end
                S_DRAIN: begin
                    if (op_ready) begin
                        done  <= 1'b1;                    // Final element is in the store
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/fixed_sqrt.sv
`timescale 1ns/1ps

module fixed_sqrt (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  chol_pkg::fixed_t radicand,
    output chol_pkg::fixed_t root,
    output logic             done
);
    import chol_pkg::*;

    localparam int OP_W  = $bits(fixed_t) + FRAC_BITS;    // Radicand << FRAC_BITS
    localparam int STEPS = OP_W / 2;                      // One root bit per step
    localparam int CNT_W = $clog2(STEPS);

    logic [OP_W-1:0]    op_q, op_in;
    logic [STEPS-1:0]   root_q, root_in;
    logic [STEPS+2:0]   rem_q, rem_in, cand, trial;
    logic [CNT_W-1:0]   cnt;
    logic               fit;

    // The start cycle runs the first step straight from the input
    always_comb begin
        op_in   = start ? {radicand, {FRAC_BITS{1'b0}}} : op_q;
        root_in = start ? '0 : root_q;
        rem_in  = start ? '0 : rem_q;
        cand    = {rem_in[STEPS:0], op_in[OP_W-1 -: 2]};  // Bring down two bits
        trial   = {1'b0, root_in, 2'b01};                 // 4 * root + 1
        fit     = cand >= trial;
    end

    always_ff @(posedge clk) begin
        if (start || cnt != '0) begin
            op_q   <= op_in << 2;
            rem_q  <= fit ? cand - trial : cand;
            root_q <= {root_in[STEPS-2:0], fit};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= !start && cnt == CNT_W'(1);           // Last step this edge
            if (start) begin
                cnt <= CNT_W'(STEPS - 1);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign root = {{($bits(fixed_t) - STEPS){1'b0}}, root_q};

endmodule

// File: logic/fixed_div.sv
`timescale 1ns/1ps

module fixed_div (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  chol_pkg::fixed_t dividend,
    input  chol_pkg::fixed_t divisor,
    output chol_pkg::fixed_t quotient,
    output logic             done
);
    import chol_pkg::*;

    localparam int EL_W  = $bits(fixed_t);
    localparam int STEPS = EL_W + FRAC_BITS;              // One quotient bit per step
    localparam int CNT_W = $clog2(STEPS);

    logic [STEPS-1:0] qd_q, qd_in;     // Dividend bits out the top, quotient bits in
    logic [EL_W:0]    rem_q, rem_in, cand;
    logic [EL_W-1:0]  dvs_q, dvs_in;
    logic [EL_W-1:0]  mag;
    logic [CNT_W-1:0] cnt;
    logic             neg_q, fit;

    // First restoring step happens on the start edge
    always_comb begin
        mag    = dividend[EL_W-1] ? EL_W'(-dividend) : EL_W'(dividend);
        qd_in  = start ? {mag, {FRAC_BITS{1'b0}}} : qd_q;
        rem_in = start ? '0 : rem_q;
        dvs_in = start ? divisor : dvs_q;
        cand   = {rem_in[EL_W-1:0], qd_in[STEPS-1]};
        fit    = cand >= {1'b0, dvs_in};
    end

    always_ff @(posedge clk) begin
        if (start || cnt != '0) begin
            qd_q  <= {qd_in[STEPS-2:0], fit};
            rem_q <= fit ? cand - {1'b0, dvs_in} : cand;
        end
        if (start) begin
            dvs_q <= divisor;                             // Store moves on after the transfer
            neg_q <= dividend[EL_W-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= !start && cnt == CNT_W'(1);
            if (start) begin
                cnt <= CNT_W'(STEPS - 1);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Magnitude quotient, sign restored so the result truncates toward zero
    assign quotient = neg_q ? -qd_q[EL_W-1:0] : qd_q[EL_W-1:0];

endmodule

// File: logic/chol_datapath.sv
`timescale 1ns/1ps

module chol_datapath (
    input  logic               clk,
    input  logic               rst,
    input  chol_pkg::chol_op_t op,
    input  logic               op_valid,
    input  chol_pkg::fixed_t   x,
    input  chol_pkg::fixed_t   y,
    input  logic               clear_error,
    output logic               op_ready,
    output chol_pkg::chol_wr_t wr,
    output logic               wr_valid,
    output logic               error
);
    import chol_pkg::*;

    logic signed [WIDE_W-1:0] acc;
    logic signed [WIDE_W-1:0] product;
    fixed_t acc_fixed;
    fixed_t root;
    fixed_t quotient;
    idx_t   dest_row;
    idx_t   dest_col;
    logic   busy, take;
    logic   sqrt_start, div_start, sqrt_done, div_done;
    logic   acc_nonpos, root_bad;

    assign op_ready   = !busy;
    assign take       = op_valid && op_ready;
    assign sqrt_start = take && op.kind == OP_SQRT;
    assign div_start  = take && op.kind == OP_DIV;
    assign product    = x * y;                            // Signed, widened before multiply
    assign acc_fixed  = acc[31:0];
    assign acc_nonpos = acc[WIDE_W-1] || acc == '0;

    // ==========================================================================
    // Multiply-accumulate, one cycle per operation

    always_ff @(posedge clk) begin
        if (take && op.kind == OP_LOAD) begin
            acc <= WIDE_W'(x);
        end else if (take && op.kind == OP_MSUB) begin
            acc <= acc - (product >>> FRAC_BITS);         // Q16.16 part is bits 47:16
        end
    end

    // ==========================================================================
    // Root and divide units, accumulator holds still while busy

    fixed_sqrt u_sqrt (
        .clk      (clk),
        .rst      (rst),
        .start    (sqrt_start),
        .radicand (acc_fixed),
        .root     (root),
        .done     (sqrt_done)
    );

    fixed_div u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (acc_fixed),
        .divisor  (x),                                    // L_jj
        .quotient (quotient),
        .done     (div_done)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            wr_valid <= 1'b0;
            error    <= 1'b0;
        end else begin
            wr_valid <= sqrt_done || div_done;
            if (sqrt_start || div_start) begin
                busy <= 1'b1;
            end else if (sqrt_done || div_done) begin
                busy <= 1'b0;
            end
            if (clear_error) begin
                error <= 1'b0;
            end else if (sqrt_start && acc_nonpos) begin
                error <= 1'b1;                            // Sticky until next load
            end
        end
    end

    // Destination and write-back payload
    always_ff @(posedge clk) begin
        if (sqrt_start || div_start) begin
            dest_row <= op.row;
            dest_col <= op.col;
        end
        if (sqrt_start) begin
            root_bad <= acc_nonpos;
        end
        if (sqrt_done || div_done) begin
            wr.row   <= dest_row;
            wr.col   <= dest_col;
            wr.value <= div_done ? quotient : (root_bad ? '0 : root);
        end
    end

endmodule

// File: logic/cholesky_top.sv
`timescale 1ns/1ps

module cholesky_top #(
    parameter int N = 5
) (
    input  logic                             clk,
    input  logic                             rst,
    input  chol_pkg::fixed_t [N*(N+1)/2-1:0] a_in,
    input  logic                             a_valid,
    output logic                             a_ready,
    output chol_pkg::fixed_t [N*(N+1)/2-1:0] l_out,
    output logic                             l_valid,
    output logic                             l_error
);
    import chol_pkg::*;

    chol_op_t op;
    chol_wr_t wr;
    fixed_t   x, y;
    idx_t     rd_a_row, rd_a_col, rd_b_row, rd_b_col;
    logic     accept, idle, done;
    logic     op_valid, op_ready, wr_valid;

    // ==========================================================================
    // Host handshake

    assign accept  = a_valid && a_ready;
    assign a_ready = idle || done;                        // Ready again on the done cycle
    assign l_valid = done;

    always_ff @(posedge clk) begin
        if (rst) begin
            idle <= 1'b1;
        end else if (accept) begin
            idle <= 1'b0;
        end else if (done) begin
            idle <= 1'b1;
        end
    end

    // ==========================================================================
    // Store, sequencer and shared datapath

    matrix_store #(.N(N)) u_store (
        .clk      (clk),
        .rst      (rst),
        .load     (accept),
        .a_in     (a_in),
        .rd_a_row (rd_a_row),
        .rd_a_col (rd_a_col),
        .rd_b_row (rd_b_row),
        .rd_b_col (rd_b_col),
        .wr       (wr),
        .wr_valid (wr_valid),
        .x        (x),
        .y        (y),
        .l_out    (l_out)
    );

    col_sequencer #(.N(N)) u_seq (
        .clk      (clk),
        .rst      (rst),
        .start    (accept),
        .op_ready (op_ready),
        .op       (op),
        .op_valid (op_valid),
        .rd_a_row (rd_a_row),
        .rd_a_col (rd_a_col),
        .rd_b_row (rd_b_row),
        .rd_b_col (rd_b_col),
        .done     (done)
    );

    chol_datapath u_dp (
        .clk         (clk),
        .rst         (rst),
        .op          (op),
        .op_valid    (op_valid),
        .x           (x),
        .y           (y),
        .clear_error (accept),                            // New matrix, fresh flag
        .op_ready    (op_ready),
        .wr          (wr),
        .wr_valid    (wr_valid),
        .error       (l_error)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk = ~clk;                                       // 50 percent duty
    end

endmodule

// File: test/tb_cholesky.sv
`timescale 1ns/1ps

module tb_cholesky;
    import chol_pkg::*;

    localparam int N            = 5;
    localparam int NUM_EL       = N * (N + 1) / 2;
    localparam int NUM_RANDOM   = 20;
    localparam int NUM_MATRICES = NUM_RANDOM + 5;         // Diagonal, pair, error pair

    typedef fixed_t [NUM_EL-1:0] tri_t;

    logic        clk, rst, a_valid, a_ready, l_valid, l_error;
    tri_t        a_in, l_out;
    logic [31:0] lfsr;
    int          errors, tests_passed, tests_failed;
    int unsigned cycles, cycle_limit;
    tri_t        exp_l_q[$];
    logic        exp_err_q[$];
    tri_t        cur_l, held_l;
    logic        cur_err, cur_known, in_flight, holding;

    tb_clock #(.PERIOD_NS(20)) u_clk (.clk(clk));

    cholesky_top #(.N(N)) uut (
        .clk     (clk),
        .rst     (rst),
        .a_in    (a_in),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .l_out   (l_out),
        .l_valid (l_valid),
        .l_error (l_error)
    );

    // ==========================================================================
    // Reference model

    function automatic int tri_index(input int r, input int c);
        return r * (r + 1) / 2 + c;                       // Row by row lower triangle
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // Diagonal in [1, 8), off-diagonal in (-4, 4), steps of 1/256
    function automatic tri_t random_factor();
        tri_t l;
        int   v;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c <= r; c++) begin
                if (r == c) begin
                    v = 256 + take_bits(11) % 1792;
                end else begin
                    v = take_bits(10);
                    if (take_bits(1) == 1) begin
                        v = -v;
                    end
                end
                l[tri_index(r, c)] = fixed_t'(v * 256);
            end
        end
        return l;
    endfunction

    // A = L * L^T is exact in Q16.16 for these ranges
    function automatic tri_t square_factor(input tri_t l);
        tri_t   a;
        fixed_t lr, lc;
        longint sum;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c <= r; c++) begin
                sum = 0;
                for (int k = 0; k <= c; k++) begin
                    lr  = l[tri_index(r, k)];
                    lc  = l[tri_index(c, k)];
                    sum = sum + longint'(lr) * longint'(lc);
                end
                a[tri_index(r, c)] = fixed_t'(sum >>> FRAC_BITS);
            end
        end
        return a;
    endfunction

    // One root or divide per element plus the load and multiply-subtract steps
    function automatic int matrix_bound();
        int acc_ops;
        acc_ops = NUM_EL;
        for (int j = 0; j < N; j++) begin
            acc_ops = acc_ops + j * (N - j);
        end
        return NUM_EL * 50 + acc_ops;
    endfunction

    // ==========================================================================
    // Checks

    task automatic check_triangle(input tri_t exp, input string what);
        fixed_t got, want;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c <= r; c++) begin
                got  = l_out[tri_index(r, c)];
                want = exp[tri_index(r, c)];
                assert (got == want) else begin
                    $display("MISMATCH l_out[%0d][%0d]%s: got %h expected %h",
                             r, c, what, got, want);
                    errors++;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            cur_known = 1'b0;
            in_flight = 1'b0;
            holding   = 1'b0;
        end else begin
            if (l_valid) begin
                assert (cur_known) else begin
                    $display("l_valid pulsed with no matrix in flight");
                    errors++;
                end
                if (cur_known) begin
                    assert (l_error == cur_err) else begin
                        $display("MISMATCH l_error: got %h expected %h", l_error, cur_err);
                        errors++;
                    end
                    if (!cur_err) begin
                        check_triangle(cur_l, "");
                    end
                end
                assert (a_ready) else begin
                    $display("MISMATCH a_ready at l_valid: got %h expected %h", a_ready, 1'b1);
                    errors++;
                end
            end else if (in_flight) begin
                assert (!a_ready) else begin
                    $display("MISMATCH a_ready while busy: got %h expected %h", a_ready, 1'b0);
                    errors++;
                end
            end
            if (holding) begin
                check_triangle(held_l, " after l_valid");
            end
            if (l_valid) begin
                holding   = cur_known && !cur_err;        // Error results carry no defined L
                held_l    = cur_l;                        // L must stay until next load
                cur_known = 1'b0;
                in_flight = 1'b0;
            end
            if (a_valid && a_ready) begin
                holding   = 1'b0;
                in_flight = 1'b1;
                if (exp_l_q.size() == 0) begin
                    $display("a matrix was accepted that the testbench never sent");
                    errors++;
                end else begin
                    cur_l     = exp_l_q.pop_front();
                    cur_err   = exp_err_q.pop_front();
                    cur_known = 1'b1;
                end
            end
        end
    end

    // ==========================================================================
    // Stimulus

    task automatic expect_result(input tri_t l, input logic err);
        exp_l_q.push_back(l);
        exp_err_q.push_back(err);
    endtask

    task automatic send_matrix(input tri_t a);
        @(negedge clk);
        a_in    = a;
        a_valid = 1'b1;
        @(posedge clk);
        while (!a_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_result();
        @(posedge clk);
        while (!l_valid) begin
            @(posedge clk);
        end
    endtask

    task automatic run_matrix(input tri_t l, input tri_t a, input logic err);
        expect_result(l, err);
        send_matrix(a);
        @(negedge clk);
        a_valid = 1'b0;
        wait_result();
    endtask

    task automatic report_test(input string name, input int start_err);
        if (errors == start_err) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors - start_err);
            tests_failed++;
        end
    endtask

    initial begin
        cycle_limit = NUM_MATRICES * matrix_bound() * 2 + 400;
        cycles      = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        tri_t l, l2, a;
        int   start_err;
        lfsr         = 32'd67005;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst          = 1'b1;
        a_valid      = 1'b0;
        a_in         = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        start_err = errors;
        @(posedge clk);
        assert (a_ready && !l_valid && !l_error) else begin
            $display("MISMATCH a_ready/l_valid/l_error after reset: got %h%h%h expected 100",
                     a_ready, l_valid, l_error);
            errors++;
        end
        report_test("reset state", start_err);

        start_err = errors;
        l = '0;
        for (int r = 0; r < N; r++) begin
            l[tri_index(r, r)] = fixed_t'((256 + (r * 397) % 1792) * 256);
        end
        run_matrix(l, square_factor(l), 1'b0);
        report_test("diagonal", start_err);

        start_err = errors;
        for (int m = 0; m < NUM_RANDOM; m++) begin
            l = random_factor();
            run_matrix(l, square_factor(l), 1'b0);
        end
        report_test("random factors", start_err);

        start_err = errors;
        l  = random_factor();
        l2 = random_factor();
        expect_result(l, 1'b0);
        expect_result(l2, 1'b0);
        send_matrix(square_factor(l));
        @(negedge clk);
        a_in = square_factor(l2);                         // Changed while busy with valid held
        wait_result();                                    // Second matrix taken here
        @(negedge clk);
        a_valid = 1'b0;
        wait_result();
        repeat (20) @(negedge clk);                       // Idle with l_out held
        report_test("busy and back to back", start_err);

        start_err = errors;
        l = '0;
        for (int r = 0; r < N; r++) begin
            l[tri_index(r, r)] = 32'h0001_0000;
        end
        l[tri_index(1, 0)] = 32'h0002_0000;
        a = square_factor(l);
        a[tri_index(1, 1)] = 32'h0001_0000;               // Second pivot goes negative
        run_matrix(l, a, 1'b1);
        l = random_factor();
        run_matrix(l, square_factor(l), 1'b0);
        report_test("negative pivot", start_err);

        assert (exp_l_q.size() == 0) else begin
            $display("%0d expected results never came out", exp_l_q.size());
            errors++;
        end
        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/chol_pkg.sv
logic/matrix_store.sv
logic/col_sequencer.sv
logic/fixed_sqrt.sv
logic/fixed_div.sv
logic/chol_datapath.sv
logic/cholesky_top.sv
test/tb_clock.sv
test/tb_cholesky.sv
